//--- design/sync_params_pkg.sv
package sync_params_pkg;

    localparam int SAMPLE_W = 32;
    localparam int HALF_W   = 16;   // one rail of a complex sample
    localparam int ACC_W    = 32;
    localparam int METRIC_W = 32;
    localparam int INDEX_W  = 16;

    localparam int NUM_STS_TAIL       = 32;  // short preamble tail
    localparam int NUM_GUARD_SKIP     = 22;  // stay clear of the cyclic prefix
    localparam int SEARCH_WINDOW      = 64;  // also the spacing of the two peaks
    localparam int CORR_LATENCY       = 6;
    localparam int MIN_SAMPLE_SPACING = 8;

    // I in the upper half, Q in the lower half, both signed
    typedef logic [SAMPLE_W-1:0]        sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic [METRIC_W-1:0]        metric_t;
    typedef logic [INDEX_W-1:0]         index_t;

    typedef enum logic [1:0] {
        skip_tail,
        skip_guard,
        search
    } skip_state_t;

endpackage

//--- design/lts_pkg.sv
package lts_pkg;

    import sync_params_pkg::*;

    localparam int LTS_LEN        = 32;
    localparam int TAPS_PER_STAGE = 8;
    localparam int NUM_STAGES     = 4;

    // long training samples, eight per correlator stage
    localparam sample_t LTS_COEFF [LTS_LEN] = '{
        // stage 0
        { 16'sd156,   16'sd0},   {-16'sd5,    16'sd120},
        { 16'sd40,    16'sd111}, { 16'sd97,  -16'sd83},
        { 16'sd21,   -16'sd28},  { 16'sd60,   16'sd88},
        {-16'sd115,   16'sd55},  {-16'sd38,   16'sd106},
        // stage 1
        { 16'sd98,    16'sd26},  { 16'sd53,  -16'sd4},
        { 16'sd1,     16'sd115}, {-16'sd137,  16'sd47},
        { 16'sd24,    16'sd59},  { 16'sd59,   16'sd15},
        {-16'sd22,   -16'sd161}, { 16'sd119,  16'sd4},
        // stage 2
        { 16'sd62,    16'sd62},  { 16'sd37,  -16'sd98},
        {-16'sd57,   -16'sd39},  {-16'sd131, -16'sd65},
        { 16'sd82,   -16'sd92},  { 16'sd70,  -16'sd14},
        {-16'sd60,   -16'sd81},  {-16'sd56,   16'sd22},
        // stage 3
        {-16'sd35,    16'sd151}, {-16'sd122,  16'sd17},
        {-16'sd127,   16'sd21},  { 16'sd75,   16'sd74},
        {-16'sd3,    -16'sd54},  {-16'sd92,  -16'sd115},
        { 16'sd92,   -16'sd106}, { 16'sd12,  -16'sd98}
    };

endpackage

//--- design/lts_cross_corr.sv
`timescale 1ns/1ps

module lts_cross_corr
    import sync_params_pkg::*;
    import lts_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  sample_t sample_i,
    input  logic    sample_valid_i,
    output metric_t metric_o,
    output logic    metric_valid_o
);

    sample_t corr_buf [LTS_LEN];   // newest sample at the top entry

    logic                          mult_busy;
    logic [$clog2(NUM_STAGES)-1:0] stage_idx;
    logic                          sum_done;   // accumulators hold the full sum
    acc_t                          stage_sum_i;
    acc_t                          stage_sum_q;
    acc_t                          acc_i;
    acc_t                          acc_q;
    metric_t                       abs_i;
    metric_t                       abs_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < LTS_LEN; k++) begin
                corr_buf[k] <= '0;
            end
        end else if (sample_valid_i) begin
            for (int k = 0; k < LTS_LEN - 1; k++) begin
                corr_buf[k] <= corr_buf[k+1];
            end
            corr_buf[LTS_LEN-1] <= sample_i;
        end
    end

    // eight taps of x * conj(c) per stage
    always_comb begin : stage_mac
        logic signed [HALF_W-1:0] x_i;
        logic signed [HALF_W-1:0] x_q;
        logic signed [HALF_W-1:0] c_i;
        logic signed [HALF_W-1:0] c_q;
        int                       tap;
        stage_sum_i = '0;
        stage_sum_q = '0;
        for (int t = 0; t < TAPS_PER_STAGE; t++) begin
            tap = int'(stage_idx) * TAPS_PER_STAGE + t;
            x_i = corr_buf[tap][SAMPLE_W-1 -: HALF_W];
            x_q = corr_buf[tap][HALF_W-1:0];
            c_i = LTS_COEFF[tap][SAMPLE_W-1 -: HALF_W];
            c_q = LTS_COEFF[tap][HALF_W-1:0];
            stage_sum_i = stage_sum_i + x_i * c_i + x_q * c_q;
            stage_sum_q = stage_sum_q + x_q * c_i - x_i * c_q;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mult_busy <= 1'b0;
            stage_idx <= '0;
            sum_done  <= 1'b0;
        end else begin
            sum_done <= 1'b0;
            if (sample_valid_i) begin
                mult_busy <= 1'b1;   // buffer shifts now, stages start next cycle
                stage_idx <= '0;
            end else if (mult_busy) begin
                stage_idx <= stage_idx + 1'b1;
                if (stage_idx == NUM_STAGES - 1) begin
                    mult_busy <= 1'b0;
                    sum_done  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mult_busy) begin
            acc_i <= (stage_idx == '0) ? stage_sum_i : acc_i + stage_sum_i;
            acc_q <= (stage_idx == '0) ? stage_sum_q : acc_q + stage_sum_q;
        end
    end

    // |I| + |Q| stands in for the true magnitude
    assign abs_i = acc_i[ACC_W-1] ? metric_t'(-acc_i) : metric_t'(acc_i);
    assign abs_q = acc_q[ACC_W-1] ? metric_t'(-acc_q) : metric_t'(acc_q);

    always_ff @(posedge clock) begin
        if (reset) begin
            metric_valid_o <= 1'b0;
        end else begin
            metric_valid_o <= sum_done;
        end
    end

    always_ff @(posedge clock) begin
        if (sum_done) begin
            metric_o <= abs_i + abs_q;
        end
    end

    a_no_strobe_when_busy: assert property (@(posedge clock) disable iff (reset)
        mult_busy |-> !sample_valid_i);

    a_metric_latency: assert property (@(posedge clock) disable iff (reset)
        sample_valid_i |-> ##CORR_LATENCY metric_valid_o);

endmodule

//--- design/preamble_skipper.sv
`timescale 1ns/1ps

module preamble_skipper
    import sync_params_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   sample_valid_i,
    output index_t sample_index_o,
    output logic   search_o
);

    index_t      strobe_cnt;   // index of the next sample
    skip_state_t state;

    always_ff @(posedge clock) begin
        if (reset) begin
            strobe_cnt     <= '0;
            sample_index_o <= '0;
            state          <= skip_tail;
        end else if (sample_valid_i) begin
            strobe_cnt     <= strobe_cnt + 1'b1;
            sample_index_o <= strobe_cnt;
            // state always describes the sample just indexed
            case (state)
                skip_tail: begin
                    if (strobe_cnt == NUM_STS_TAIL) state <= skip_guard;
                end
                skip_guard: begin
                    if (strobe_cnt == NUM_STS_TAIL + NUM_GUARD_SKIP) state <= search;
                end
                search:  state <= search;
                default: state <= skip_tail;
            endcase
        end
    end

    assign search_o = (state == search);

    a_search_sticky: assert property (@(posedge clock) disable iff (reset)
        state == search |=> state == search);

endmodule

//--- design/peak_picker.sv
`timescale 1ns/1ps

module peak_picker
    import sync_params_pkg::*;
    import lts_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  metric_t metric_i,
    input  logic    metric_valid_i,
    input  index_t  sample_index_i,
    input  logic    search_i,
    output logic    done_o,
    output logic    detected_o,
    output index_t  lts_start_o
);

    typedef enum logic [1:0] {
        pick_first,
        pick_second,
        pick_idle
    } pick_state_t;

    pick_state_t                      state;
    logic [$clog2(SEARCH_WINDOW)-1:0] metric_cnt;
    metric_t                          max_metric;
    index_t                           peak_idx;
    index_t                           second_idx;
    logic                             accept;

    assign accept     = metric_valid_i && search_i;
    assign second_idx = index_t'(peak_idx + SEARCH_WINDOW);

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= pick_first;
            metric_cnt  <= '0;
            done_o      <= 1'b0;
            detected_o  <= 1'b0;
            lts_start_o <= '0;
        end else begin
            done_o <= 1'b0;
            case (state)
                pick_first: begin
                    if (accept) begin
                        metric_cnt <= metric_cnt + 1'b1;
                        if (metric_cnt == SEARCH_WINDOW - 1) state <= pick_second;
                    end
                end
                pick_second: begin
                    if (accept && sample_index_i == second_idx) begin
                        done_o      <= 1'b1;
                        detected_o  <= (metric_i >= (max_metric >> 1));  // half the first peak
                        lts_start_o <= index_t'(peak_idx - (LTS_LEN - 1));
                        state       <= pick_idle;
                    end
                end
                default: state <= pick_idle;   // wait for reset
            endcase
        end
    end

    // running maximum, strict compare keeps the earliest of equal peaks
    always_ff @(posedge clock) begin
        if (state == pick_first && accept) begin
            if (metric_cnt == '0 || metric_i > max_metric) begin
                max_metric <= metric_i;
                peak_idx   <= sample_index_i;
            end
        end
    end

    a_done_single: assert property (@(posedge clock) disable iff (reset)
        done_o |=> !done_o);

endmodule

//--- design/sync_long.sv
`timescale 1ns/1ps

module sync_long
    import sync_params_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  sample_t sample_i,
    input  logic    sample_valid_i,
    output metric_t metric_o,
    output logic    metric_valid_o,
    output logic    done_o,
    output logic    detected_o,
    output index_t  lts_start_o
);

    index_t sample_index;
    logic   search;

    lts_cross_corr corr_i (
        .clock          (clock),
        .reset          (reset),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .metric_o       (metric_o),
        .metric_valid_o (metric_valid_o)
    );

    preamble_skipper skipper_i (
        .clock          (clock),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_index_o (sample_index),
        .search_o       (search)
    );

    // index and search still belong to the metric's sample on metric_valid
    peak_picker picker_i (
        .clock          (clock),
        .reset          (reset),
        .metric_i       (metric_o),
        .metric_valid_i (metric_valid_o),
        .sample_index_i (sample_index),
        .search_i       (search),
        .done_o         (done_o),
        .detected_o     (detected_o),
        .lts_start_o    (lts_start_o)
    );

endmodule

//--- tests/tb_sync_long.sv
`timescale 1ns/1ps

module tb_sync_long;

    logic        clock;
    logic        reset;
    logic [31:0] sample_i;
    logic        sample_valid_i;
    logic [31:0] metric_o;
    logic        metric_valid_o;
    logic        done_o;
    logic        detected_o;
    logic [15:0] lts_start_o;

    // long training values, I then Q
    int coeff_i [32] = '{156, -5, 40, 97, 21, 60, -115, -38, 98, 53, 1, -137, 24, 59, -22, 119,
                         62, 37, -57, -131, 82, 70, -60, -56, -35, -122, -127, 75, -3, -92, 92, 12};
    int coeff_q [32] = '{0, 120, 111, -83, -28, 88, 55, 106, 26, -4, 115, 47, 59, 15, -161, 4,
                         62, -98, -39, -65, -92, -14, -81, 22, 151, 17, 21, 74, -54, -115, -106, -98};

    logic [31:0] stim [0:255];
    logic [31:0] lfsr;
    logic [31:0] hist [32];        // model delay line, oldest at 0
    longint      model_metric [0:1023];
    longint      exp_queue [$];
    longint      strobe_cycle [$];
    longint      cycle_cnt;
    int          strobe_cnt;       // samples seen since reset
    int          done_cnt;
    logic        got_detected;
    logic [15:0] got_start;

    sync_long sync_long_i (
        .clock          (clock),
        .reset          (reset),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .metric_o       (metric_o),
        .metric_valid_o (metric_valid_o),
        .done_o         (done_o),
        .detected_o     (detected_o),
        .lts_start_o    (lts_start_o)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // x * conj(c) summed over the window, then |re| + |im|
    function automatic longint ref_metric();
        longint re;
        longint im;
        longint xi;
        longint xq;
        re = 0;
        im = 0;
        for (int k = 0; k < 32; k++) begin
            xi = longint'($signed(hist[k][31:16]));
            xq = longint'($signed(hist[k][15:0]));
            re += xi * coeff_i[k] + xq * coeff_q[k];
            im += xq * coeff_i[k] - xi * coeff_q[k];
        end
        if (re < 0) re = -re;
        if (im < 0) im = -im;
        return re + im;
    endfunction

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = (value << 1) | lfsr[0];
        end
        return value;
    endfunction

    task automatic noise_sample(output logic [31:0] s);
        int ni;
        int nq;
        ni = take_bits(9);
        nq = take_bits(9);
        ni = (ni == 0) ? -255 : ni - 256;   // keep within +-255
        nq = (nq == 0) ? -255 : nq - 256;
        s = {ni[15:0], nq[15:0]};
    endtask

    task automatic send_sample(input logic [31:0] s);
        @(posedge clock);
        sample_i       <= s;
        sample_valid_i <= 1'b1;
        @(posedge clock);
        sample_valid_i <= 1'b0;
        repeat (6) @(posedge clock);   // 7 idle cycles before the next strobe
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
    endtask

    // strobe, metric and done monitor
    always @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) hist[k] = '0;
            exp_queue.delete();
            strobe_cycle.delete();
            cycle_cnt  = 0;
            strobe_cnt = 0;
            done_cnt   = 0;
        end else begin
            cycle_cnt++;
            if (sample_valid_i) begin
                for (int k = 0; k < 31; k++) hist[k] = hist[k+1];
                hist[31] = sample_i;
                model_metric[strobe_cnt] = ref_metric();
                exp_queue.push_back(model_metric[strobe_cnt]);
                strobe_cycle.push_back(cycle_cnt);
                strobe_cnt++;
            end
            if (metric_valid_o) begin
                if (exp_queue.size() == 0) begin
                    $display("A metric came out with no sample strobe before it");
                    $display("Test FAILED");
                    $fatal(1);
                end
                check_value("metric latency", cycle_cnt - strobe_cycle.pop_front(), 6);
                check_value("metric", longint'(metric_o), exp_queue.pop_front());
            end
            if (done_o) begin
                if (strobe_cnt < 54 + 64) begin
                    $display("done came after only %0d samples", strobe_cnt);
                    $display("Test FAILED");
                    $fatal(1);
                end
                done_cnt++;
                got_detected = detected_o;
                got_start    = lts_start_o;
            end
        end
    end

    initial begin
        int     ptr;
        int     n_scen;
        int     noise_len;
        int     n_samples;
        int     extra;
        int     best_idx;
        longint best;
        logic [31:0] s;
        logic   exp_det;
        int     exp_start;

        reset          = 1'b1;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        lfsr           = 32'h690d_fea4;
        $readmemh("tests/sync_long_stimulus.txt", stim);
        n_scen = stim[0];
        ptr    = 1;

        for (int sc = 0; sc < n_scen; sc++) begin
            noise_len = stim[ptr];
            n_samples = stim[ptr+1];
            exp_det   = stim[ptr+2][0];
            exp_start = stim[ptr+3];
            ptr += 4;
            apply_reset();
            for (int i = 0; i < noise_len; i++) begin
                noise_sample(s);
                send_sample(s);
            end
            for (int i = 0; i < n_samples; i++) begin
                send_sample(stim[ptr+i]);
            end
            ptr += n_samples;
            extra = 0;
            while (done_cnt == 0) begin   // pad with noise until the verdict
                if (extra == 300) begin
                    $display("Timed out waiting for done in scenario %0d", sc);
                    $display("Test FAILED");
                    $fatal(1);
                end
                noise_sample(s);
                send_sample(s);
                extra++;
            end
            repeat (20) @(posedge clock);
            check_value("metrics still pending", exp_queue.size(), 0);
            check_value("done pulse count", done_cnt, 1);
            check_value("detected", got_detected, exp_det);
            check_value("lts start", got_start, exp_start);
            // the first peak from the model must agree with the file
            best     = -1;
            best_idx = 0;
            for (int i = 54; i < 54 + 64; i++) begin
                if (model_metric[i] > best) begin
                    best     = model_metric[i];
                    best_idx = i;
                end
            end
            check_value("model peak start", best_idx - 31, exp_start);
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- files.f
design/sync_params_pkg.sv
design/lts_pkg.sv
design/lts_cross_corr.sv
design/preamble_skipper.sv
design/peak_picker.sv
design/sync_long.sv
tests/tb_sync_long.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_sync_long
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then exit 1; fi
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/sync_long_stimulus.txt
// word 0 is the scenario count; each scenario: noise_len sample_count exp_detected exp_start
// then sample_count samples, I in the upper 16 bits and Q in the lower 16 bits
00000002
00000028 00000060 00000001 00000028
04e00000 ffd803c0 01400378 0308fd68
00a8ff20 01e002c0 fc6801b8 fed00350
031000d0 01a8ffe0 00080398 fbb80178
00c001d8 01d80078 ff50faf8 03b80020
01f001f0 0128fcf0 fe38fec8 fbe8fdf8
0290fd20 0230ff90 fe20fd78 fe4000b0
fee804b8 fc300088 fc0800a8 02580250
ffe8fe50 fd20fc68 02e0fcb0 0060fcf0
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
04e00000 ffd803c0 01400378 0308fd68
00a8ff20 01e002c0 fc6801b8 fed00350
031000d0 01a8ffe0 00080398 fbb80178
00c001d8 01d80078 ff50faf8 03b80020
01f001f0 0128fcf0 fe38fec8 fbe8fdf8
0290fd20 0230ff90 fe20fd78 fe4000b0
fee804b8 fc300088 fc0800a8 02580250
ffe8fe50 fd20fc68 02e0fcb0 0060fcf0
0000001e 00000040 00000000 0000001e
04e00000 ffd803c0 01400378 0308fd68
00a8ff20 01e002c0 fc6801b8 fed00350
031000d0 01a8ffe0 00080398 fbb80178
00c001d8 01d80078 ff50faf8 03b80020
01f001f0 0128fcf0 fe38fec8 fbe8fdf8
0290fd20 0230ff90 fe20fd78 fe4000b0
fee804b8 fc300088 fc0800a8 02580250
ffe8fe50 fd20fc68 02e0fcb0 0060fcf0
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
